//--- icap_port_pkg.sv
// Shared types for the ICAP port endpoint; word width fixed at 32 bits, one access port only
`default_nettype none

package icap_port_pkg;

  // --------------------------------------------------------------------------
  // Constants
  // --------------------------------------------------------------------------

  // Request to valid icap_dout, in cycles
  localparam int ICAP_RD_LATENCY = 2;
  // Bytes per configuration word
  localparam int WORD_BYTES = 4;
  // Word count width, requests and status
  localparam int WCOUNT_W = 16;
  // Byte index within a word
  localparam int BYTE_IDX_W = $clog2(WORD_BYTES);
  // Enough to count out the read latency
  localparam int LAT_W = $clog2(ICAP_RD_LATENCY + 1);

  // --------------------------------------------------------------------------
  // Types
  // --------------------------------------------------------------------------

  // One byte beat of a frame
  typedef struct packed {
    logic [7:0] data;
    logic       sof;
    logic       eof;
  } stream_beat_t;

  // One access on the configuration port, write high means write
  typedef struct packed {
    logic        ce;
    logic        write;
    logic [31:0] din;
  } icap_req_t;

  typedef enum logic [3:0] {
    PORT_CFG_WR = 4'd3,
    PORT_CFG_RD = 4'd4
  } port_id_e;

  typedef enum logic [2:0] {
    RD_IDLE,
    RD_LEN_LO,
    RD_ISSUE,
    RD_WAIT,
    RD_SEND
  } rd_state_e;

endpackage

`default_nettype wire

//--- icap_write_path.sv
// Port-3 bytes pack big-endian into words; a short tail at eof is dropped and flagged in wr_partial
`timescale 1ns/1ps
`default_nettype none

module icap_write_path
  import icap_port_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  stream_beat_t        out_beat,
  input  logic                wr_take,
  output logic                wr_dst_rdy,
  output icap_req_t           wr_req,
  input  logic                wr_gnt,
  output logic [WCOUNT_W-1:0] wr_words,
  output logic                wr_partial
);

  logic [BYTE_IDX_W-1:0] byte_idx;
  logic [BYTE_IDX_W-1:0] idx_now;
  logic                  word_last;
  logic                  pending;
  logic [31:0]           word_q;

  // sof restarts the word, whatever was left over
  assign idx_now   = out_beat.sof ? '0 : byte_idx;
  assign word_last = (idx_now == BYTE_IDX_W'(WORD_BYTES - 1));

  // Hold the platform off while a word waits for the port
  assign wr_dst_rdy = !pending;

  // Request is live from the cycle after the fourth byte
  assign wr_req = '{ce: pending, write: 1'b1, din: word_q};

  // --------------------------------------------------------------------------
  // Byte packing and write status
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      byte_idx   <= '0;
      pending    <= 1'b0;
      wr_words   <= '0;
      wr_partial <= 1'b0;
    end else begin
      // Word goes out on grant
      if (wr_gnt) begin
        pending  <= 1'b0;
        wr_words <= wr_words + 1'b1;
      end
      if (wr_take) begin
        // New frame clears status
        if (out_beat.sof) begin
          wr_words   <= '0;
          wr_partial <= 1'b0;
        end
        if (word_last) begin
          byte_idx <= '0;
          pending  <= 1'b1;
        end else if (out_beat.eof) begin
          // Frame ended mid-word, bytes so far are dropped
          byte_idx   <= '0;
          wr_partial <= 1'b1;
        end else begin
          byte_idx <= idx_now + 1'b1;
        end
      end
    end
  end

  // Shift in MSB first, four takes fill the word
  always_ff @(posedge clk) begin
    if (wr_take) begin
      word_q <= {word_q[23:0], out_beat.data};
    end
  end

  // Back-pressure must hold while the word is pending
  assert property (@(posedge clk) disable iff (reset) pending |-> !wr_take);

endmodule

`default_nettype wire

//--- icap_read_path.sv
// Port-4 request holds a 16-bit big-endian word count; one word in flight, extra request bytes ignored
`timescale 1ns/1ps
`default_nettype none

module icap_read_path
  import icap_port_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  stream_beat_t out_beat,
  input  logic         rd_take,
  output logic         rd_dst_rdy,
  output icap_req_t    rd_req,
  input  logic         rd_gnt,
  input  logic [31:0]  icap_dout,
  output stream_beat_t rd_beat,
  output logic         rd_src_rdy,
  input  logic         rd_give
);

  rd_state_e             state;
  logic [WCOUNT_W-1:0]   words_left;
  logic [WCOUNT_W-1:0]   len_final;
  logic                  len_done;
  logic                  first_beat;
  logic [BYTE_IDX_W-1:0] byte_idx;
  logic                  last_byte;
  logic [LAT_W-1:0]      lat_cnt;
  logic                  lat_done;
  logic [31:0]           word_q;

  // Low byte may arrive on the eof beat itself
  assign len_final = len_done ? words_left : {words_left[WCOUNT_W-1:8], out_beat.data};
  assign last_byte = (byte_idx == BYTE_IDX_W'(WORD_BYTES - 1));
  assign lat_done  = (lat_cnt == LAT_W'(ICAP_RD_LATENCY - 1));

  // No new request taken while a reply is running
  assign rd_dst_rdy = (state == RD_IDLE) || (state == RD_LEN_LO);
  assign rd_req     = '{ce: (state == RD_ISSUE), write: 1'b0, din: '0};
  assign rd_src_rdy = (state == RD_SEND);
  assign rd_beat    = '{data: word_q[31:24], sof: first_beat,
                        eof: last_byte && (words_left == 1)};

  // --------------------------------------------------------------------------
  // Request parse and readback FSM
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= RD_IDLE;
      words_left <= '0;
      len_done   <= 1'b0;
      first_beat <= 1'b0;
      byte_idx   <= '0;
      lat_cnt    <= '0;
    end else begin
      case (state)
        RD_IDLE: begin
          // High count byte; stray bytes without sof are skipped
          if (rd_take && out_beat.sof) begin
            words_left <= {out_beat.data, 8'h00};
            len_done   <= 1'b0;
            if (!out_beat.eof) state <= RD_LEN_LO;
          end
        end
        RD_LEN_LO: begin
          if (rd_take) begin
            if (!len_done) begin
              words_left[7:0] <= out_beat.data;
              len_done        <= 1'b1;
            end
            if (out_beat.eof) begin
              words_left <= len_final;
              first_beat <= 1'b1;
              // Zero count, nothing to send
              state <= (len_final == '0) ? RD_IDLE : RD_ISSUE;
            end
          end
        end
        RD_ISSUE: begin
          if (rd_gnt) begin
            lat_cnt <= '0;
            state   <= RD_WAIT;
          end
        end
        RD_WAIT: begin
          // icap_dout valid ICAP_RD_LATENCY cycles after grant
          if (lat_done) begin
            byte_idx <= '0;
            state    <= RD_SEND;
          end else begin
            lat_cnt <= lat_cnt + 1'b1;
          end
        end
        RD_SEND: begin
          if (rd_give) begin
            first_beat <= 1'b0;
            byte_idx   <= byte_idx + 1'b1;
            if (last_byte) begin
              words_left <= words_left - 1'b1;
              state      <= (words_left == 1) ? RD_IDLE : RD_ISSUE;
            end
          end
        end
        default: state <= RD_IDLE;
      endcase
    end
  end

  // Capture then shift out MSB first
  always_ff @(posedge clk) begin
    if (state == RD_WAIT && lat_done) begin
      word_q <= icap_dout;
    end else if (rd_give) begin
      word_q <= {word_q[23:0], 8'h00};
    end
  end

  // Arbiter strobe only when a byte is on offer
  assert property (@(posedge clk) disable iff (reset) rd_give |-> rd_src_rdy);

endmodule

`default_nettype wire

//--- icap_port_arbiter.sv
// Write has fixed priority; writes are held off while a read result is returning
`timescale 1ns/1ps
`default_nettype none

module icap_port_arbiter
  import icap_port_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  port_id_e     outport,
  input  port_id_e     inport,
  input  logic         plat_out_src_rdy,
  input  logic         plat_in_dst_rdy,
  input  logic         wr_dst_rdy,
  input  logic         rd_dst_rdy,
  input  logic         rd_src_rdy,
  input  stream_beat_t rd_beat,
  input  icap_req_t    wr_req,
  input  icap_req_t    rd_req,
  output logic         wr_take,
  output logic         rd_take,
  output logic         rd_give,
  output logic         wr_gnt,
  output logic         rd_gnt,
  output logic         plat_out_dst_rdy,
  output logic         plat_in_src_rdy,
  output stream_beat_t plat_in,
  output icap_req_t    icap_req
);

  logic [LAT_W-1:0] lock_cnt;

  // --------------------------------------------------------------------------
  // Stream steering
  // --------------------------------------------------------------------------

  // Unknown outports are sunk, always ready
  always_comb begin
    case (outport)
      PORT_CFG_WR: plat_out_dst_rdy = wr_dst_rdy;
      PORT_CFG_RD: plat_out_dst_rdy = rd_dst_rdy;
      default:     plat_out_dst_rdy = 1'b1;
    endcase
  end

  assign wr_take = (outport == PORT_CFG_WR) && plat_out_src_rdy && wr_dst_rdy;
  assign rd_take = (outport == PORT_CFG_RD) && plat_out_src_rdy && rd_dst_rdy;

  // Only port 4 has anything to return
  assign plat_in_src_rdy = (inport == PORT_CFG_RD) && rd_src_rdy;
  assign plat_in         = (inport == PORT_CFG_RD) ? rd_beat : '0;
  assign rd_give         = plat_in_src_rdy && plat_in_dst_rdy;

  // --------------------------------------------------------------------------
  // Access port grant
  // --------------------------------------------------------------------------

  assign wr_gnt   = wr_req.ce && (lock_cnt == '0);
  assign rd_gnt   = rd_req.ce && !wr_gnt;
  assign icap_req = wr_gnt ? wr_req : (rd_gnt ? rd_req : '0);

  // Counts down the read return window
  always_ff @(posedge clk) begin
    if (reset) begin
      lock_cnt <= '0;
    end else if (rd_gnt) begin
      lock_cnt <= LAT_W'(ICAP_RD_LATENCY);
    end else if (lock_cnt != '0) begin
      lock_cnt <= lock_cnt - 1'b1;
    end
  end

  // No write while the data of a granted read returns
  assert property (@(posedge clk) disable iff (reset)
    rd_gnt |=> (!wr_gnt) [*ICAP_RD_LATENCY]);

endmodule

`default_nettype wire

//--- icap_port_top.sv
// Single clock domain; ports other than 3 and 4 are sunk on out and idle on in
`timescale 1ns/1ps
`default_nettype none

module icap_port_top
  import icap_port_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  // Platform to endpoint
  input  stream_beat_t        plat_out,
  input  logic                plat_out_src_rdy,
  input  port_id_e            outport,
  output logic                plat_out_dst_rdy,
  // Endpoint to platform
  output stream_beat_t        plat_in,
  output logic                plat_in_src_rdy,
  input  port_id_e            inport,
  input  logic                plat_in_dst_rdy,
  // Configuration port
  output icap_req_t           icap_req,
  input  logic [31:0]         icap_dout,
  // Write status
  output logic [WCOUNT_W-1:0] wr_words,
  output logic                wr_partial
);

  logic         wr_take, rd_take, rd_give;
  logic         wr_gnt, rd_gnt;
  logic         wr_dst_rdy, rd_dst_rdy, rd_src_rdy;
  icap_req_t    wr_req, rd_req;
  stream_beat_t rd_beat;

  icap_write_path u_write_path (
    .clk, .reset, .out_beat(plat_out), .wr_take, .wr_dst_rdy,
    .wr_req, .wr_gnt, .wr_words, .wr_partial
  );

  icap_read_path u_read_path (
    .clk, .reset, .out_beat(plat_out), .rd_take, .rd_dst_rdy,
    .rd_req, .rd_gnt, .icap_dout, .rd_beat, .rd_src_rdy, .rd_give
  );

  icap_port_arbiter u_arbiter (
    .clk, .reset, .outport, .inport, .plat_out_src_rdy, .plat_in_dst_rdy,
    .wr_dst_rdy, .rd_dst_rdy, .rd_src_rdy, .rd_beat, .wr_req, .rd_req,
    .wr_take, .rd_take, .rd_give, .wr_gnt, .rd_gnt,
    .plat_out_dst_rdy, .plat_in_src_rdy, .plat_in, .icap_req
  );

endmodule

`default_nettype wire

//--- tb_icap_port_top.sv
// Directed testbench; ICAP is a 256-word memory model whose read pointer the tests can rewind
`timescale 1ns/1ps
`default_nettype none

module tb_icap_port_top
  import icap_port_pkg::*;
();

  logic                clk = 1'b0;
  logic                reset;
  stream_beat_t        plat_out;
  logic                plat_out_src_rdy;
  port_id_e            outport;
  logic                plat_out_dst_rdy;
  stream_beat_t        plat_in;
  logic                plat_in_src_rdy;
  port_id_e            inport;
  logic                plat_in_dst_rdy;
  icap_req_t           icap_req;
  logic [31:0]         icap_dout;
  logic [WCOUNT_W-1:0] wr_words;
  logic                wr_partial;

  // Memory model state
  logic [31:0] mem [256];
  logic [31:0] rd_pipe [ICAP_RD_LATENCY] = '{default: '0};
  logic [7:0]  wr_ptr = '0;
  logic [7:0]  rd_ptr = '0;
  logic        rd_rewind;
  logic [31:0] wr_log [$];
  int          accesses = 0;
  int          src_leaks = 0;
  int          errors = 0;
  int          tests = 0;
  int          wait_limit = 200;

  icap_port_top u_dut (.*);

  always #5 clk = ~clk;

  // --------------------------------------------------------------------------
  // ICAP memory model
  // --------------------------------------------------------------------------

  // Last pipe stage is the read data
  assign icap_dout = rd_pipe[ICAP_RD_LATENCY-1];

  always @(posedge clk) begin
    for (int i = ICAP_RD_LATENCY - 1; i > 0; i--) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
    rd_pipe[0] <= '0;
    if (reset) begin
      // Fill pattern uses every address bit
      for (int a = 0; a < 256; a++) begin
        mem[a] <= {8'hc5, 8'(a), ~8'(a), 8'(a) ^ 8'h3c};
      end
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      accesses <= 0;
    end else if (icap_req.ce) begin
      accesses <= accesses + 1;
      if (icap_req.write) begin
        mem[wr_ptr] <= icap_req.din;
        wr_log.push_back(icap_req.din);
        wr_ptr <= wr_ptr + 1'b1;
      end else begin
        rd_pipe[0] <= mem[rd_ptr];
        rd_ptr     <= rd_ptr + 1'b1;
      end
    end else if (rd_rewind) begin
      rd_ptr <= '0;
    end
  end

  // Reply stream must stay idle on any inport but 4
  always @(negedge clk) begin
    if (inport != PORT_CFG_RD && plat_in_src_rdy) src_leaks <= src_leaks + 1;
  end

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input logic [WCOUNT_W-1:0] got, input logic [WCOUNT_W-1:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_beat(input stream_beat_t got, input stream_beat_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %h sof=%b eof=%b, expected %h sof=%b eof=%b", $time,
               what, got.data, got.sof, got.eof, exp.data, exp.sof, exp.eof);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int e0);
    tests++;
    if (errors == e0) $display("PASS %s", name);
    else $display("FAIL %s with %0d errors", name, errors - e0);
  endtask

  // --------------------------------------------------------------------------
  // Drivers, called 1 ns after a rising edge and returning there
  // --------------------------------------------------------------------------

  task automatic send_frame(input port_id_e port, input logic [7:0] bytes [$]);
    int   cycles;
    logic taken;
    outport = port;
    for (int i = 0; i < bytes.size(); i++) begin
      plat_out         = '{data: bytes[i], sof: (i == 0), eof: (i == bytes.size() - 1)};
      plat_out_src_rdy = 1'b1;
      taken            = 1'b0;
      cycles           = 0;
      // Ready sampled mid-cycle, byte moves on the next edge
      while (!taken && cycles < wait_limit) begin
        @(negedge clk);
        taken = plat_out_dst_rdy;
        @(posedge clk);
        #1;
        cycles++;
      end
      if (!taken) begin
        $display("Timeout: port %0d never accepted byte %0d", port, i);
        errors++;
        break;
      end
    end
    plat_out_src_rdy = 1'b0;
    plat_out         = '0;
  endtask

  task automatic recv_frame(input logic stall, output stream_beat_t got [$]);
    int   cycles;
    logic done;
    done   = 1'b0;
    cycles = 0;
    while (!done && cycles < wait_limit) begin
      // Random stall about one cycle in three
      plat_in_dst_rdy = stall ? (($urandom % 3) != 0) : 1'b1;
      @(negedge clk);
      if (plat_in_src_rdy && plat_in_dst_rdy) begin
        got.push_back(plat_in);
        done = plat_in.eof;
      end
      @(posedge clk);
      #1;
      cycles++;
    end
    plat_in_dst_rdy = 1'b0;
    if (!done) begin
      $display("Timeout: reply frame never reached its last byte");
      errors++;
    end
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------

  task automatic reset_test();
    int e0;
    e0 = errors;
    check_flag(plat_in_src_rdy, 1'b0, "plat_in_src_rdy");
    check_flag(icap_req.ce, 1'b0, "icap_req.ce");
    check_flag(wr_partial, 1'b0, "wr_partial");
    check_flag(plat_out_dst_rdy, 1'b1, "plat_out_dst_rdy");
    check_count(wr_words, '0, "wr_words");
    report_test("reset values", e0);
  endtask

  task automatic write_test(input int n);
    logic [7:0]  bytes [$];
    logic [31:0] exp;
    int          cycles;
    int          e0;
    e0 = errors;
    wr_log.delete();
    for (int i = 0; i < n; i++) bytes.push_back(8'($urandom));
    send_frame(PORT_CFG_WR, bytes);
    // Last word is granted after the frame ends
    cycles = 0;
    while (wr_log.size() < n / WORD_BYTES && cycles < wait_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (wr_log.size() < n / WORD_BYTES) begin
      $display("Timeout: only %0d writes reached the configuration port", wr_log.size());
      errors++;
    end
    check_count(WCOUNT_W'(wr_log.size()), WCOUNT_W'(n / WORD_BYTES), "write count");
    for (int w = 0; w < n / WORD_BYTES && w < wr_log.size(); w++) begin
      exp = {bytes[4*w], bytes[4*w+1], bytes[4*w+2], bytes[4*w+3]};
      check_word(wr_log[w], exp, $sformatf("written word %0d", w));
    end
    check_count(wr_words, WCOUNT_W'(n / WORD_BYTES), "wr_words");
    check_flag(wr_partial, (n % WORD_BYTES) != 0, "wr_partial");
    @(posedge clk);
    #1;
    report_test($sformatf("write frame of %0d bytes", n), e0);
  endtask

  task automatic read_test(input logic stall);
    logic [7:0]   req [$];
    stream_beat_t got [$];
    stream_beat_t exp;
    logic [31:0]  word;
    int           e0;
    e0 = errors;
    // Both readbacks start at address 0
    rd_rewind = 1'b1;
    @(posedge clk);
    #1;
    rd_rewind = 1'b0;
    inport    = PORT_CFG_RD;
    // Count 3, then one byte the endpoint ignores
    req.push_back(8'h00);
    req.push_back(8'd3);
    req.push_back(8'h5a);
    send_frame(PORT_CFG_RD, req);
    recv_frame(stall, got);
    check_count(WCOUNT_W'(got.size()), WCOUNT_W'(3 * WORD_BYTES), "reply length");
    for (int i = 0; i < got.size() && i < 3 * WORD_BYTES; i++) begin
      word     = mem[i / WORD_BYTES];
      exp.data = word[31 - 8 * (i % WORD_BYTES) -: 8];
      exp.sof  = (i == 0);
      exp.eof  = (i == 3 * WORD_BYTES - 1);
      check_beat(got[i], exp, $sformatf("reply byte %0d", i));
    end
    report_test(stall ? "readback with stalls" : "readback", e0);
  endtask

  task automatic other_port_test();
    logic [7:0]   bytes [$];
    logic [7:0]   req [$];
    stream_beat_t got [$];
    int           a0;
    int           cycles;
    int           e0;
    e0     = errors;
    a0     = accesses;
    inport = port_id_e'(4'd7);
    for (int i = 0; i < 8; i++) bytes.push_back(8'($urandom));
    send_frame(port_id_e'(4'd7), bytes);
    check_count(WCOUNT_W'(accesses - a0), '0, "ICAP accesses for port 7");
    // One-word reply waits behind inport 7
    a0 = accesses;
    req.push_back(8'h00);
    req.push_back(8'd1);
    send_frame(PORT_CFG_RD, req);
    cycles = 0;
    while (accesses == a0 && cycles < wait_limit) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (accesses == a0) begin
      $display("Timeout: port 4 request never read the configuration port");
      errors++;
    end
    // Reply byte is on offer once the read latency has passed
    repeat (ICAP_RD_LATENCY + 4) @(posedge clk);
    #1;
    check_count(WCOUNT_W'(src_leaks), '0, "cycles with plat_in_src_rdy on port 7");
    inport = PORT_CFG_RD;
    recv_frame(1'b0, got);
    check_count(WCOUNT_W'(got.size()), WCOUNT_W'(WORD_BYTES), "reply length after port 7");
    report_test("port 7 sink", e0);
  endtask

  initial begin
    void'($urandom(32'h42194f07));
    reset            = 1'b1;
    plat_out         = '0;
    plat_out_src_rdy = 1'b0;
    outport          = PORT_CFG_WR;
    inport           = PORT_CFG_RD;
    plat_in_dst_rdy  = 1'b0;
    rd_rewind        = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    reset_test();
    write_test(12);
    write_test(6);
    read_test(1'b0);
    read_test(1'b1);
    other_port_test();
    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
icap_port_pkg.sv
icap_write_path.sv
icap_read_path.sv
icap_port_arbiter.sv
icap_port_top.sv
tb_icap_port_top.sv

//--- Makefile
# Verilator flow for the ICAP port endpoint
VERILATOR ?= verilator
TOP       ?= tb_icap_port_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# Result is taken from the log, not the exit code
sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "No errors" $(LOG); then echo "Simulation did not finish"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
